// ==== hdl/mem_arb_pkg.sv ====
package mem_arb_pkg;

  localparam int ADDR_BITS   = 16;
  localparam int RAM_LATENCY = 2;  // BUSY cycles before ACCESS
  localparam int SP_ROWS     = 4;

  typedef logic [31:0]          word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef enum logic [1:0] {
    FREE   = 2'b00,
    BUSY   = 2'b01,
    ACCESS = 2'b10
  } ramstate_t;

  // Grant order follows the priority list
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    SP_LOAD  = 3'b001,
    SP_STORE = 3'b010,
    DCACHE   = 3'b011,
    ICACHE   = 3'b100
  } arb_state_t;

endpackage

// ==== hdl/ram_ctrl.sv ====
`timescale 1ns/1ps

module ram_ctrl
  import mem_arb_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      ramren,
  input  logic      ramwen,
  input  addr_t     ramaddr,
  input  word_t     ramstore,
  output ramstate_t ramstate,
  output word_t     ramload
);

  word_t     mem [2**ADDR_BITS];
  ramstate_t seq_state;
  logic [$clog2(RAM_LATENCY+1)-1:0] lat_cnt;
  logic      ram_req;
  logic      in_access;

  assign ram_req   = ramren || ramwen;
  assign in_access = (seq_state == ACCESS);

  // First busy cycle is the one where the request shows up
  always_comb begin
    if (seq_state == FREE && ram_req) begin
      ramstate = BUSY;
    end
    else begin
      ramstate = seq_state;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      seq_state <= FREE;
      lat_cnt   <= '0;
    end
    else begin
      case (seq_state)
        FREE: begin
          if (ram_req) begin
            lat_cnt   <= $bits(lat_cnt)'(1);
            seq_state <= (RAM_LATENCY == 1) ? ACCESS : BUSY;
          end
        end

        BUSY: begin
          lat_cnt <= lat_cnt + 1'b1;
          if (lat_cnt == $bits(lat_cnt)'(RAM_LATENCY - 1)) begin
            seq_state <= ACCESS;
          end
        end

        ACCESS: begin
          seq_state <= FREE;  // Always one ACCESS cycle
          lat_cnt   <= '0;
        end

        default: begin
          seq_state <= FREE;
          lat_cnt   <= '0;
        end
      endcase
    end
  end

  // Storage starts out cleared
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 2**ADDR_BITS; i++) begin
        mem[i] <= '0;
      end
    end
    else if (in_access && ramwen) begin
      mem[ramaddr] <= ramstore;  // Commits at end of ACCESS
    end
  end

  assign ramload = (in_access && ramren) ? mem[ramaddr] : '0;

  a_addr_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (ramstate == BUSY) |=> $stable(ramaddr)
  ) else $error("ramaddr changed during access");

endmodule

// ==== hdl/memory_arbiter.sv ====
`timescale 1ns/1ps

module memory_arbiter
  import mem_arb_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  // Scratchpad
  input  logic      sp_load,
  input  logic      sp_store,
  input  addr_t     sp_load_addr,
  input  addr_t     sp_store_addr,
  input  word_t     sp_store_data,
  output word_t     sp_load_data,
  output logic      sp_load_hit,
  output logic      sp_store_hit,
  output logic [2:0] sp_row,
  // Data cache
  input  logic      dren,
  input  logic      dwen,
  input  addr_t     daddr,
  input  word_t     dstore,
  output logic      dwait,
  output word_t     dload,
  // Instruction cache
  input  logic      iren,
  input  addr_t     iaddr,
  output logic      iwait,
  output word_t     iload,
  // RAM side
  output logic      ramren,
  output logic      ramwen,
  output addr_t     ramaddr,
  output word_t     ramstore,
  input  ramstate_t ramstate,
  input  word_t     ramload
);

  arb_state_t arb_state, next_arb_state;
  logic       ram_done;

  assign ram_done = (ramstate == ACCESS);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arb_state <= IDLE;
    end
    else begin
      arb_state <= next_arb_state;
    end
  end

  always_comb begin
    next_arb_state = arb_state;
    case (arb_state)
      IDLE: begin
        if (sp_load) next_arb_state = SP_LOAD;
        else if (sp_store) next_arb_state = SP_STORE;
        else if (dren || dwen) next_arb_state = DCACHE;
        else if (iren) next_arb_state = ICACHE;
      end

      SP_LOAD, SP_STORE, DCACHE, ICACHE: begin
        if (ram_done) begin
          next_arb_state = IDLE;  // Release after the access cycle
        end
      end

      default: begin
        next_arb_state = IDLE;
      end
    endcase
  end

  // RAM bus and load data routing
  always_comb begin
    ramren       = 1'b0;
    ramwen       = 1'b0;
    ramaddr      = '0;
    ramstore     = '0;
    sp_load_data = '0;
    dload        = '0;
    iload        = '0;
    case (arb_state)
      SP_LOAD: begin
        ramren       = sp_load;
        ramaddr      = sp_load_addr;
        sp_load_data = ramload;
      end

      SP_STORE: begin
        ramwen   = sp_store;
        ramaddr  = sp_store_addr;
        ramstore = sp_store_data;
      end

      DCACHE: begin
        ramwen   = dwen;
        ramren   = dren && !dwen;  // Write wins
        ramaddr  = daddr;
        ramstore = dstore;
        dload    = ramload;
      end

      ICACHE: begin
        ramren  = iren;
        ramaddr = iaddr;
        iload   = ramload;
      end

      default: begin
        ramren = 1'b0;
      end
    endcase
  end

  // Completion strobes and waits
  assign sp_load_hit  = (arb_state == SP_LOAD) && ram_done;
  assign sp_store_hit = (arb_state == SP_STORE) && ram_done;
  assign dwait = (dren || dwen) && !((arb_state == DCACHE) && ram_done);
  assign iwait = iren && !((arb_state == ICACHE) && ram_done);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sp_row <= 3'd0;
    end
    else if (sp_store_hit) begin
      if (sp_row == 3'd0 || sp_row == 3'(SP_ROWS)) begin
        sp_row <= 3'd1;
      end
      else begin
        sp_row <= sp_row + 3'd1;
      end
    end
  end

  a_ram_onehot: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(ramren && ramwen)
  ) else $error("ramren and ramwen both high");

  // Grant held until the RAM reports ACCESS
  a_grant_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (arb_state != IDLE && ramstate != ACCESS) |=> (arb_state == $past(arb_state))
  ) else $error("grant left before ACCESS");

endmodule

// ==== hdl/memory_subsystem.sv ====
`timescale 1ns/1ps

module memory_subsystem
  import mem_arb_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  // Scratchpad port
  input  logic       sp_load,
  input  logic       sp_store,
  input  addr_t      sp_load_addr,
  input  addr_t      sp_store_addr,
  input  word_t      sp_store_data,
  output word_t      sp_load_data,
  output logic       sp_load_hit,
  output logic       sp_store_hit,
  output logic [2:0] sp_row,
  // Data cache port
  input  logic       dren,
  input  logic       dwen,
  input  addr_t      daddr,
  input  word_t      dstore,
  output logic       dwait,
  output word_t      dload,
  // Instruction cache port
  input  logic       iren,
  input  addr_t      iaddr,
  output logic       iwait,
  output word_t      iload
);

  logic      ramren;
  logic      ramwen;
  addr_t     ramaddr;
  word_t     ramstore;
  ramstate_t ramstate;
  word_t     ramload;

  memory_arbiter u_arbiter (
    .CLK           (CLK),
    .nRST          (nRST),
    .sp_load       (sp_load),
    .sp_store      (sp_store),
    .sp_load_addr  (sp_load_addr),
    .sp_store_addr (sp_store_addr),
    .sp_store_data (sp_store_data),
    .sp_load_data  (sp_load_data),
    .sp_load_hit   (sp_load_hit),
    .sp_store_hit  (sp_store_hit),
    .sp_row        (sp_row),
    .dren          (dren),
    .dwen          (dwen),
    .daddr         (daddr),
    .dstore        (dstore),
    .dwait         (dwait),
    .dload         (dload),
    .iren          (iren),
    .iaddr         (iaddr),
    .iwait         (iwait),
    .iload         (iload),
    .ramren        (ramren),
    .ramwen        (ramwen),
    .ramaddr       (ramaddr),
    .ramstore      (ramstore),
    .ramstate      (ramstate),
    .ramload       (ramload)
  );

  ram_ctrl u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramren   (ramren),
    .ramwen   (ramwen),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramstate (ramstate),
    .ramload  (ramload)
  );

endmodule

// ==== tests/tb_memory_subsystem.sv ====
`timescale 1ns/1ps

module tb_memory_subsystem
  import mem_arb_pkg::*;
();

  localparam int WAIT_LIMIT = 20;  // Cycles allowed per response

  logic       CLK;
  logic       nRST;
  logic       sp_load;
  logic       sp_store;
  addr_t      sp_load_addr;
  addr_t      sp_store_addr;
  word_t      sp_store_data;
  word_t      sp_load_data;
  logic       sp_load_hit;
  logic       sp_store_hit;
  logic [2:0] sp_row;
  logic       dren;
  logic       dwen;
  addr_t      daddr;
  word_t      dstore;
  logic       dwait;
  word_t      dload;
  logic       iren;
  addr_t      iaddr;
  logic       iwait;
  word_t      iload;

  int err_count;
  int pass_tests;
  int fail_tests;
  int test_num;

  memory_subsystem u_memory_subsystem (
    .CLK           (CLK),
    .nRST          (nRST),
    .sp_load       (sp_load),
    .sp_store      (sp_store),
    .sp_load_addr  (sp_load_addr),
    .sp_store_addr (sp_store_addr),
    .sp_store_data (sp_store_data),
    .sp_load_data  (sp_load_data),
    .sp_load_hit   (sp_load_hit),
    .sp_store_hit  (sp_store_hit),
    .sp_row        (sp_row),
    .dren          (dren),
    .dwen          (dwen),
    .daddr         (daddr),
    .dstore        (dstore),
    .dwait         (dwait),
    .dload         (dload),
    .iren          (iren),
    .iaddr         (iaddr),
    .iwait         (iwait),
    .iload         (iload)
  );

  always #50 CLK = ~CLK;

  function automatic string port_name(input string op_name);
    if (op_name == "sp_load" || op_name == "sp_store") return "scratchpad";
    else if (op_name == "i_read") return "instruction cache";
    else return "data cache";
  endfunction

  // Raise or drop one requester's request with its address and data
  task automatic drive_request(input string op_name, input addr_t addr, input word_t data,
                               input logic on);
    if (op_name == "sp_load") begin
      sp_load      = on;
      sp_load_addr = addr;
    end
    else if (op_name == "sp_store") begin
      sp_store      = on;
      sp_store_addr = addr;
      sp_store_data = data;
    end
    else if (op_name == "d_read") begin
      dren  = on;
      daddr = addr;
    end
    else if (op_name == "d_write") begin
      dwen   = on;
      daddr  = addr;
      dstore = data;
    end
    else begin
      iren  = on;
      iaddr = addr;
    end
  endtask

  task automatic run_single(input string op_name, input addr_t addr, input word_t data,
                            input word_t exp_data, input logic [2:0] exp_row);
    int    cycles;
    logic  done;
    word_t got;
    string data_name;
    string done_name;
    cycles    = 0;
    done      = 1'b0;
    got       = '0;
    data_name = "";
    done_name = "iwait";
    drive_request(op_name, addr, data, 1'b1);
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      if (op_name == "sp_load") begin
        done      = sp_load_hit;
        got       = sp_load_data;
        data_name = "sp_load_data";
        done_name = "sp_load_hit";
      end
      else if (op_name == "sp_store") begin
        done      = sp_store_hit;
        done_name = "sp_store_hit";
      end
      else if (op_name == "d_read" || op_name == "d_write") begin
        done      = !dwait;
        got       = dload;
        data_name = (op_name == "d_read") ? "dload" : "";
        done_name = "dwait";
      end
      else begin
        done      = !iwait;
        got       = iload;
        data_name = "iload";
      end
    end
    if (!done) begin
      $display("Timeout: no completion on the %s port within %0d cycles",
               port_name(op_name), WAIT_LIMIT);
      err_count++;
    end
    else begin
      if (cycles != RAM_LATENCY + 1) begin
        $display("CHECK FAILED at %0t: %s completion cycle expected %0d, got %0d",
                 $time, done_name, RAM_LATENCY + 1, cycles);
        err_count++;
      end
      if (data_name != "" && got !== exp_data) begin
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, data_name, exp_data, got);
        err_count++;
      end
    end
    @(negedge CLK);  // Request held through the completion edge
    if (sp_row !== exp_row) begin
      $display("CHECK FAILED at %0t: sp_row expected %0d, got %0d", $time, exp_row, sp_row);
      err_count++;
    end
    drive_request(op_name, addr, data, 1'b0);
  endtask

  // Scratchpad load, data cache read and icache read raised together
  task automatic run_group(input addr_t addr, input word_t exp_data, input logic [2:0] exp_row);
    int    cycles;
    int    sp_at;
    int    d_at;
    int    i_at;
    logic  sp_seen;
    logic  d_seen;
    logic  i_seen;
    word_t sp_word;
    word_t d_word;
    word_t i_word;
    cycles       = 0;
    sp_at        = 0;
    d_at         = 0;
    i_at         = 0;
    sp_load      = 1'b1;
    sp_load_addr = addr;
    dren         = 1'b1;
    daddr        = addr;
    iren         = 1'b1;
    iaddr        = addr;
    while ((sp_load || dren || iren) && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      sp_seen = sp_load && sp_load_hit;
      d_seen  = dren && !dwait;
      i_seen  = iren && !iwait;
      sp_word = sp_load_data;
      d_word  = dload;
      i_word  = iload;
      if (sp_at != 0) sp_load = 1'b0;  // One cycle after completion
      if (d_at != 0) dren = 1'b0;
      if (i_at != 0) iren = 1'b0;
      if (sp_seen && sp_at == 0) begin
        sp_at = cycles;
        if (sp_word !== exp_data) begin
          $display("CHECK FAILED at %0t: sp_load_data expected %h, got %h", $time, exp_data, sp_word);
          err_count++;
        end
      end
      if (d_seen && d_at == 0) begin
        d_at = cycles;
        if (d_word !== exp_data) begin
          $display("CHECK FAILED at %0t: dload expected %h, got %h", $time, exp_data, d_word);
          err_count++;
        end
      end
      if (i_seen && i_at == 0) begin
        i_at = cycles;
        if (i_word !== exp_data) begin
          $display("CHECK FAILED at %0t: iload expected %h, got %h", $time, exp_data, i_word);
          err_count++;
        end
      end
    end
    sp_load = 1'b0;
    dren    = 1'b0;
    iren    = 1'b0;
    if (sp_at == 0 || d_at == 0 || i_at == 0) begin
      $display("Timeout: grouped requests not all served within %0d cycles (sp %0d, d %0d, i %0d)",
               WAIT_LIMIT, sp_at, d_at, i_at);
      err_count++;
    end
    else begin
      if (sp_at != RAM_LATENCY + 1) begin
        $display("CHECK FAILED at %0t: sp_load_hit cycle expected %0d, got %0d",
                 $time, RAM_LATENCY + 1, sp_at);
        err_count++;
      end
      if (d_at < sp_at + RAM_LATENCY + 2) begin
        $display("CHECK FAILED at %0t: dwait fall cycle expected >= %0d, got %0d",
                 $time, sp_at + RAM_LATENCY + 2, d_at);
        err_count++;
      end
      if (i_at < d_at + RAM_LATENCY + 2) begin
        $display("CHECK FAILED at %0t: iwait fall cycle expected >= %0d, got %0d",
                 $time, d_at + RAM_LATENCY + 2, i_at);
        err_count++;
      end
    end
    if (sp_row !== exp_row) begin
      $display("CHECK FAILED at %0t: sp_row expected %0d, got %0d", $time, exp_row, sp_row);
      err_count++;
    end
  endtask

  task automatic report_test(input string label, input int errs_before);
    test_num++;
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %0d %s: ok", test_num, label);
    end
    else begin
      fail_tests++;
      $display("test %0d %s: failed", test_num, label);
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    fields;
    int    gap;
    int    row_val;
    int    errs_before;
    string text_line;
    string op_name;
    addr_t addr;
    word_t data;
    word_t exp_data;
    CLK           = 1'b0;
    nRST          = 1'b0;
    sp_load       = 1'b0;
    sp_store      = 1'b0;
    sp_load_addr  = '0;
    sp_store_addr = '0;
    sp_store_data = '0;
    dren          = 1'b0;
    dwen          = 1'b0;
    daddr         = '0;
    dstore        = '0;
    iren          = 1'b0;
    iaddr         = '0;
    err_count     = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    test_num      = 0;
    void'($urandom(32'hdccd41cf));

    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    errs_before = err_count;
    if (dwait !== 1'b0) begin
      $display("CHECK FAILED at %0t: dwait expected 0, got %b", $time, dwait);
      err_count++;
    end
    if (iwait !== 1'b0) begin
      $display("CHECK FAILED at %0t: iwait expected 0, got %b", $time, iwait);
      err_count++;
    end
    if (sp_load_hit !== 1'b0) begin
      $display("CHECK FAILED at %0t: sp_load_hit expected 0, got %b", $time, sp_load_hit);
      err_count++;
    end
    if (sp_store_hit !== 1'b0) begin
      $display("CHECK FAILED at %0t: sp_store_hit expected 0, got %b", $time, sp_store_hit);
      err_count++;
    end
    if (sp_row !== 3'd0) begin
      $display("CHECK FAILED at %0t: sp_row expected 0, got %0d", $time, sp_row);
      err_count++;
    end
    report_test("reset state", errs_before);

    fd = $fopen("tests/mem_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/mem_input.txt");
      err_count++;
    end
    else begin
      while (!$feof(fd)) begin
        text_line = "";
        op_name   = "";
        fields    = 0;
        n = $fgets(text_line, fd);
        if (n > 0) begin
          fields = $sscanf(text_line, "%s %h %h %h %d", op_name, addr, data, exp_data, row_val);
        end
        if (fields == 5) begin  // Comment and blank lines skipped
          gap = $urandom_range(3, 0);
          repeat (gap) @(negedge CLK);
          errs_before = err_count;
          if (op_name == "grp_read") begin
            run_group(addr, exp_data, 3'(row_val));
          end
          else if (op_name == "sp_load" || op_name == "sp_store" || op_name == "d_read" ||
                   op_name == "d_write" || op_name == "i_read") begin
            run_single(op_name, addr, data, exp_data, 3'(row_val));
          end
          else begin
            $display("Unknown operation %s in the input file", op_name);
            err_count++;
          end
          report_test($sformatf("%s %h", op_name, addr), errs_before);
        end
      end
      $fclose(fd);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display(">>> PASS");
    end
    else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/mem_arb_pkg.sv
hdl/ram_ctrl.sv
hdl/memory_arbiter.sv
hdl/memory_subsystem.sv
tests/tb_memory_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_memory_subsystem \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tests/mem_input.txt ====
# op addr data expected row
# addr, data and expected are hex, row is the sp_row value after the operation
d_read   0040 00000000 00000000 0
d_write  0010 cafe0001 00000000 0
d_read   0010 00000000 cafe0001 0
sp_store 0020 12345678 00000000 1
i_read   0020 00000000 12345678 1
sp_load  0020 00000000 12345678 1
d_write  0030 0badf00d 00000000 1
sp_load  0030 00000000 0badf00d 1
grp_read 0010 00000000 cafe0001 1
sp_store 0100 a0000001 00000000 2
sp_store 0101 a0000002 00000000 3
sp_store 0102 a0000003 00000000 4
sp_store 0103 a0000004 00000000 1
sp_load  0102 00000000 a0000003 1
d_write  ffff 55aa55aa 00000000 1
i_read   ffff 00000000 55aa55aa 1
d_read   0101 00000000 a0000002 1
grp_read 0030 00000000 0badf00d 1
